// File: Makefile
# Verilator build and run of the audio mixer testbench

TOP := tb_audio_mixer

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -j 0 --top-module $(TOP) -f files.f

run: build
	./obj_dir/V$(TOP) > sim.log 2>&1
	@cat sim.log
	@if grep -q "=== FAIL ===" sim.log; then exit 1; fi

lint:
	verilator --lint-only --timing -Wall --top-module audio_mixer_top -f files.f

clean:
	rm -rf obj_dir sim.log

// File: files.f
source/audio_pkg.sv
source/regs_pkg.sv
source/frame_assembler.sv
source/channel_mixer.sv
source/frame_serializer.sv
source/mixer_regs.sv
source/audio_mixer_top.sv
sim/mixer_checker.sv
sim/tb_audio_mixer.sv

// File: sim/mixer_checker.sv
// watches the ADC, DAC and register ports of the mixer core
// model of the mixing rule and register map, compares DAC words and reads
// config writes and status reads assumed only while the stream is idle

`timescale 1ns/100ps
`default_nettype none

module mixer_checker #(
  parameter int Q_BITS = audio_pkg::Q_BITS
) (
  input  wire                     clk,
  input  wire                     rst_n,
  input  wire audio_pkg::sample_t adc_data,
  input  wire                     adc_last,
  input  wire                     adc_valid,
  input  wire                     adc_ready,
  input  wire audio_pkg::sample_t dac_data,
  input  wire                     dac_last,
  input  wire                     dac_valid,
  input  wire                     dac_ready,
  input  wire regs_pkg::reg_req_t reg_req,
  input  wire                     reg_ack,
  input  wire regs_pkg::data_t    reg_rdata,
  output int                      error_count,
  output int                      check_count,
  output int                      pending
);

  import audio_pkg::*;
  import regs_pkg::*;

  localparam longint SAT_MAX = 64'sd8388607;   // 2**23 - 1
  localparam longint SAT_MIN = -64'sd8388608;

  typedef struct packed {
    logic    last;
    sample_t data;
  } dac_word_t;

  dac_word_t  exp_q [$];      // expected DAC words, oldest first
  gain_t      m_out_gain;
  gain_t      m_ch_gain [2];
  logic [1:0] m_pan;
  logic [2:0] m_clip;         // out, ch1, ch0
  sample_t    m_max;
  sample_t    m_min;
  sample_t    m_left;         // channel 0 of the frame being paired
  logic       ack_q;
  logic       rst_seen;

  function automatic longint clamp(input longint v);
    if (v > SAT_MAX) begin
      return SAT_MAX;
    end
    if (v < SAT_MIN) begin
      return SAT_MIN;
    end
    return v;
  endfunction

  // product, then floor of the division by 2**Q_BITS
  function automatic longint scale(input longint v, input longint g);
    return (v * g) >>> Q_BITS;
  endfunction

  task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("Mismatch at %0t: %s got 0x%08h expected 0x%08h", $time, what, got, exp);
    end
  endtask

  task automatic reset_model;
    exp_q.delete();
    m_out_gain   = 24'd1 << Q_BITS;   // unity
    m_ch_gain[0] = 24'd1 << Q_BITS;
    m_ch_gain[1] = 24'd1 << Q_BITS;
    m_pan        = 2'b10;             // ch0 left, ch1 right
    m_clip       = '0;
    m_max        = 24'sh80_0000;
    m_min        = 24'sh7F_FFFF;
    m_left       = '0;
    ack_q        = 1'b0;
    rst_seen     = 1'b0;
  endtask

  // ---------------------------------------------------------------------
  // mixing model
  // ---------------------------------------------------------------------
  task automatic push_frame(input sample_t ch0, input sample_t ch1);
    longint raw0;
    longint raw1;
    longint sum_l;
    longint sum_r;
    longint out_l;
    longint out_r;
    raw0 = scale(ch0, m_ch_gain[0]);
    raw1 = scale(ch1, m_ch_gain[1]);
    if (clamp(raw0) != raw0) m_clip[0] = 1'b1;
    if (clamp(raw1) != raw1) m_clip[1] = 1'b1;
    sum_l = 0;
    sum_r = 0;
    if (m_pan[0]) sum_r += clamp(raw0);
    else          sum_l += clamp(raw0);
    if (m_pan[1]) sum_r += clamp(raw1);
    else          sum_l += clamp(raw1);
    out_l = scale(sum_l, m_out_gain);
    out_r = scale(sum_r, m_out_gain);
    if (clamp(out_l) != out_l || clamp(out_r) != out_r) m_clip[2] = 1'b1;
    exp_q.push_back({1'b0, sample_t'(clamp(out_l))});   // left first
    exp_q.push_back({1'b1, sample_t'(clamp(out_r))});
  endtask

  function automatic data_t expected_read(input addr_t addr);
    case (addr)
      ADDR_VERSION:  return 32'd2058;
      ADDR_OUT_GAIN: return {8'h00, m_out_gain};
      ADDR_CH0_GAIN: return {8'h00, m_ch_gain[0]};
      ADDR_CH1_GAIN: return {8'h00, m_ch_gain[1]};
      ADDR_PAN:      return {30'd0, m_pan};
      ADDR_MAX_AMP:  return {{8{m_max[23]}}, m_max};   // sign extended
      ADDR_MIN_AMP:  return {{8{m_min[23]}}, m_min};
      ADDR_CLIP:     return {29'd0, m_clip};
      default:       return 32'd0;
    endcase
  endfunction

  task automatic apply_write(input addr_t addr, input data_t data);
    case (addr)
      ADDR_OUT_GAIN: m_out_gain   = data[23:0];
      ADDR_CH0_GAIN: m_ch_gain[0] = data[23:0];
      ADDR_CH1_GAIN: m_ch_gain[1] = data[23:0];
      ADDR_PAN:      m_pan        = data[1:0];
      ADDR_CMD: begin
        if (data[0]) begin
          m_max = 24'sh80_0000;   // re-armed peaks
          m_min = 24'sh7F_FFFF;
        end
        if (data[1]) m_clip = '0;
      end
      default: ;                  // read-only or unmapped
    endcase
  endtask

  task automatic take_dac;
    dac_word_t exp;
    if (exp_q.size() == 0) begin
      error_count++;
      $display("Error at %0t: DAC sent a sample while no frame was expected", $time);
    end else begin
      exp = exp_q.pop_front();
      compare("DAC data", dac_data, exp.data);
      compare("DAC last", dac_last, exp.last);
    end
  endtask

  // ---------------------------------------------------------------------
  // port watcher, samples on the rising edge
  // ---------------------------------------------------------------------
  always @(posedge clk) begin : watch_p
    if (!rst_n) begin
      reset_model();
    end else begin
      if (!rst_seen) begin
        compare("dac_valid after reset", dac_valid, 32'd0);
        compare("reg_ack after reset", reg_ack, 32'd0);
        compare("adc_ready after reset", adc_ready, 32'd1);
        rst_seen = 1'b1;
      end
      if (adc_valid && adc_ready) begin
        if (adc_data > m_max) m_max = adc_data;
        if (adc_data < m_min) m_min = adc_data;
        if (adc_last) push_frame(m_left, adc_data);
        else          m_left = adc_data;
      end
      if (dac_valid && dac_ready) take_dac();
      if (reg_ack && !ack_q) begin              // ack just rose, request still held
        if (reg_req.write) apply_write(reg_req.addr, reg_req.data);
        else compare($sformatf("read of 0x%02h", reg_req.addr), reg_rdata,
                     expected_read(reg_req.addr));
      end
      ack_q = reg_ack;
    end
    pending = exp_q.size();
  end

endmodule

`default_nettype wire

// File: sim/tb_audio_mixer.sv
// audio mixer core driven with random frames from a fixed seed
// inputs change on the falling edge and mixer_checker does the comparing
// every wait is bounded by TIMEOUT cycles

`timescale 1ns/100ps
`default_nettype none

module tb_audio_mixer;

  import audio_pkg::*;
  import regs_pkg::*;

  localparam int TB_Q_BITS = 7;
  localparam int TIMEOUT   = 2000;   // cycles per wait

  logic     clk = 1'b0;
  logic     rst_n;
  sample_t  adc_data;
  logic     adc_last;
  logic     adc_valid;
  logic     adc_ready;
  sample_t  dac_data;
  logic     dac_last;
  logic     dac_valid;
  logic     dac_ready = 1'b0;
  reg_req_t reg_req;
  logic     reg_req_valid;
  logic     reg_ack;
  data_t    reg_rdata;
  int       seed    = 32'h0164_0fbd;
  int       bp_seed = 32'h0164_0fbd ^ 32'h2a2a_5151;   // own stream for dac_ready
  int       timeouts;
  int       last_errors;
  int       error_count;
  int       check_count;
  int       pending;

  always #5 clk = ~clk;

  audio_mixer_top #(
    .Q_BITS ( TB_Q_BITS )
  ) i_dut (
    .clk           ( clk           ),
    .rst_n         ( rst_n         ),
    .adc_data      ( adc_data      ),
    .adc_last      ( adc_last      ),
    .adc_valid     ( adc_valid     ),
    .adc_ready     ( adc_ready     ),
    .dac_data      ( dac_data      ),
    .dac_last      ( dac_last      ),
    .dac_valid     ( dac_valid     ),
    .dac_ready     ( dac_ready     ),
    .reg_req       ( reg_req       ),
    .reg_req_valid ( reg_req_valid ),
    .reg_ack       ( reg_ack       ),
    .reg_rdata     ( reg_rdata     )
  );

  mixer_checker #(
    .Q_BITS ( TB_Q_BITS )
  ) i_checker (
    .clk         ( clk         ),
    .rst_n       ( rst_n       ),
    .adc_data    ( adc_data    ),
    .adc_last    ( adc_last    ),
    .adc_valid   ( adc_valid   ),
    .adc_ready   ( adc_ready   ),
    .dac_data    ( dac_data    ),
    .dac_last    ( dac_last    ),
    .dac_valid   ( dac_valid   ),
    .dac_ready   ( dac_ready   ),
    .reg_req     ( reg_req     ),
    .reg_ack     ( reg_ack     ),
    .reg_rdata   ( reg_rdata   ),
    .error_count ( error_count ),
    .check_count ( check_count ),
    .pending     ( pending     )
  );

  // random DAC back-pressure with ready three cycles in four
  always @(negedge clk) begin : backpressure_p
    if (rst_n) begin
      dac_ready = ($random(bp_seed) & 3) != 0;
    end
  end

  task automatic note_timeout(input string what);
    timeouts++;
    $display("Timeout at %0t: %s", $time, what);
  endtask

  task automatic finish_test(input int num, input string name);
    $display("test %0d %s done, %0d new errors", num, name,
             error_count + timeouts - last_errors);
    last_errors = error_count + timeouts;
  endtask

  // one four-phase access that starts and ends on a falling edge
  task automatic reg_access(input logic write, input addr_t addr, input data_t data);
    int waited;
    reg_req       = {write, addr, data};
    reg_req_valid = 1'b1;
    waited = 0;
    while (!reg_ack && waited < TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (!reg_ack) note_timeout("reg_ack never rose");
    reg_req_valid = 1'b0;
    waited = 0;
    while (reg_ack && waited < TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (reg_ack) note_timeout("reg_ack never fell");
  endtask

  task automatic send_sample(input sample_t data, input logic last);
    int gap;
    int waited;
    gap       = $random(seed) & 3;
    adc_valid = 1'b0;
    repeat (gap) @(negedge clk);   // random valid gap
    adc_data  = data;
    adc_last  = last;
    adc_valid = 1'b1;
    waited = 0;
    while (!adc_ready && waited < TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (!adc_ready) note_timeout("adc_ready stayed low");
    @(negedge clk);                // taken on the rising edge in between
    adc_valid = 1'b0;
  endtask

  task automatic send_frames(input int count, input logic full_scale);
    sample_t l;
    sample_t r;
    for (int i = 0; i < count; i++) begin
      l = sample_t'($random(seed));
      r = sample_t'($random(seed));
      if (full_scale) begin
        l = l[0] ? SAMPLE_MAX : SAMPLE_MIN;
        r = r[0] ? SAMPLE_MAX : SAMPLE_MIN;
      end
      send_sample(l, 1'b0);
      send_sample(r, 1'b1);
    end
  endtask

  task automatic wait_drained;
    int waited;
    waited = 0;
    while ((pending != 0 || dac_valid) && waited < TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (pending != 0 || dac_valid) note_timeout("DAC stream did not drain");
  endtask

  initial begin
    rst_n         = 1'b0;
    adc_data      = '0;
    adc_last      = 1'b0;
    adc_valid     = 1'b0;
    reg_req       = '0;
    reg_req_valid = 1'b0;
    timeouts      = 0;
    last_errors   = 0;
    repeat (8) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    // reset defaults plus read-only version and unmapped read
    reg_access(1'b0, ADDR_VERSION, '0);
    reg_access(1'b1, ADDR_VERSION, 32'hFFFF_FFFF);
    reg_access(1'b0, ADDR_VERSION, '0);
    reg_access(1'b0, ADDR_OUT_GAIN, '0);
    reg_access(1'b0, ADDR_CH0_GAIN, '0);
    reg_access(1'b0, ADDR_CH1_GAIN, '0);
    reg_access(1'b0, ADDR_PAN, '0);
    reg_access(1'b0, 7'h24, '0);
    finish_test(1, "reset defaults");

    send_frames(40, 1'b0);         // unity gains so out equals in
    wait_drained();
    finish_test(2, "pass-through");

    for (int round = 0; round < 3; round++) begin
      reg_access(1'b1, ADDR_OUT_GAIN, $random(seed) & 32'h1FF);
      reg_access(1'b1, ADDR_CH0_GAIN, $random(seed) & 32'h1FF);
      reg_access(1'b1, ADDR_CH1_GAIN, $random(seed) & 32'h1FF);
      reg_access(1'b1, ADDR_PAN, $random(seed) & 32'h3);
      reg_access(1'b0, ADDR_CH0_GAIN, '0);
      reg_access(1'b0, ADDR_PAN, '0);
      send_frames(24, 1'b0);
      wait_drained();
    end
    finish_test(3, "random mixing");

    reg_access(1'b1, ADDR_CMD, 32'h2);           // start from a clean clip status
    reg_access(1'b1, ADDR_CH0_GAIN, 32'h4000);   // 128.0
    reg_access(1'b1, ADDR_CH1_GAIN, 32'h80);     // unity so ch1 never clips
    reg_access(1'b1, ADDR_OUT_GAIN, 32'h100);
    send_frames(8, 1'b1);
    wait_drained();
    reg_access(1'b0, ADDR_CLIP, '0);
    reg_access(1'b1, ADDR_CMD, 32'h2);           // clip clear
    reg_access(1'b0, ADDR_CLIP, '0);
    finish_test(4, "saturation");

    reg_access(1'b0, ADDR_MAX_AMP, '0);
    reg_access(1'b0, ADDR_MIN_AMP, '0);
    reg_access(1'b1, ADDR_CMD, 32'h1);           // re-arm peaks
    reg_access(1'b0, ADDR_MAX_AMP, '0);
    reg_access(1'b0, ADDR_MIN_AMP, '0);
    send_frames(6, 1'b0);
    wait_drained();
    reg_access(1'b0, ADDR_MAX_AMP, '0);
    reg_access(1'b0, ADDR_MIN_AMP, '0);
    finish_test(5, "peak tracking");

    $display("checks %0d, errors %0d, timeouts %0d", check_count, error_count, timeouts);
    if (error_count == 0 && timeouts == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: source/audio_mixer_top.sv
// audio mixer core: ADC stream in, DAC stream out, four-phase register port
// latency depends on DAC back-pressure

`timescale 1ns/100ps
`default_nettype none

module audio_mixer_top #(
  parameter int Q_BITS = audio_pkg::Q_BITS
) (
  input  wire                    clk,
  input  wire                    rst_n,
  // ADC stream
  input  wire audio_pkg::sample_t adc_data,
  input  wire                    adc_last,
  input  wire                    adc_valid,
  output logic                   adc_ready,
  // DAC stream
  output audio_pkg::sample_t     dac_data,
  output logic                   dac_last,
  output logic                   dac_valid,
  input  wire                    dac_ready,
  // register port
  input  wire regs_pkg::reg_req_t reg_req,
  input  wire                    reg_req_valid,
  output logic                   reg_ack,
  output regs_pkg::data_t        reg_rdata
);

  import audio_pkg::*;

  frame_t   frm;
  logic     frm_valid;
  logic     frm_ready;
  frame_t   mix;
  logic     mix_valid;
  logic     mix_ready;
  logic     mix_fire;   // frame handed to the serializer
  clip_t    clip;
  mix_cfg_t cfg;
  logic     peak_clear;
  sample_t  max_amp;
  sample_t  min_amp;

  assign mix_fire = mix_valid && mix_ready;

  frame_assembler i_assembler (
    .clk        ( clk        ),
    .rst_n      ( rst_n      ),
    .adc_data   ( adc_data   ),
    .adc_last   ( adc_last   ),
    .adc_valid  ( adc_valid  ),
    .adc_ready  ( adc_ready  ),
    .frm        ( frm        ),
    .frm_valid  ( frm_valid  ),
    .frm_ready  ( frm_ready  ),
    .peak_clear ( peak_clear ),
    .max_amp    ( max_amp    ),
    .min_amp    ( min_amp    )
  );

  channel_mixer #(
    .Q_BITS ( Q_BITS )
  ) i_mixer (
    .clk       ( clk       ),
    .rst_n     ( rst_n     ),
    .frm       ( frm       ),
    .frm_valid ( frm_valid ),
    .frm_ready ( frm_ready ),
    .cfg       ( cfg       ),
    .mix       ( mix       ),
    .mix_valid ( mix_valid ),
    .mix_ready ( mix_ready ),
    .clip      ( clip      )
  );

  frame_serializer i_serializer (
    .clk       ( clk       ),
    .rst_n     ( rst_n     ),
    .mix       ( mix       ),
    .mix_valid ( mix_valid ),
    .mix_ready ( mix_ready ),
    .dac_data  ( dac_data  ),
    .dac_last  ( dac_last  ),
    .dac_valid ( dac_valid ),
    .dac_ready ( dac_ready )
  );

  mixer_regs i_regs (
    .clk           ( clk           ),
    .rst_n         ( rst_n         ),
    .reg_req       ( reg_req       ),
    .reg_req_valid ( reg_req_valid ),
    .reg_ack       ( reg_ack       ),
    .reg_rdata     ( reg_rdata     ),
    .cfg           ( cfg           ),
    .peak_clear    ( peak_clear    ),
    .max_amp       ( max_amp       ),
    .min_amp       ( min_amp       ),
    .clip          ( clip          ),
    .clip_valid    ( mix_fire      )  // clip counts only with a taken frame
  );

endmodule

`default_nettype wire

// File: source/audio_pkg.sv
// sample, gain and mixer configuration types shared by the audio path
// gains are unsigned fixed point with Q_BITS fraction bits
// the mixer core is fixed at two channels

`default_nettype none

package audio_pkg;

  localparam int AUDIO_WIDTH    = 24;
  localparam int GAIN_WIDTH     = 24;
  localparam int NR_OF_CHANNELS = 2;
  localparam int Q_BITS         = 7;   // default fraction bits

  typedef logic signed [AUDIO_WIDTH-1:0] sample_t;
  typedef logic        [GAIN_WIDTH-1:0]  gain_t;

  localparam gain_t UNITY_GAIN = gain_t'(1) << Q_BITS;  // 1.0, 128 at Q_BITS 7

  // saturation limits, also the re-armed peak values
  localparam sample_t SAMPLE_MAX = {1'b0, {(AUDIO_WIDTH-1){1'b1}}};
  localparam sample_t SAMPLE_MIN = {1'b1, {(AUDIO_WIDTH-1){1'b0}}};

  // ---------------------------------------------------------------------
  // stream and config structs
  // ---------------------------------------------------------------------
  typedef struct packed {
    sample_t left;
    sample_t right;
  } frame_t;  // 48 bits

  // pan bit per channel, 0 routes left and 1 routes right
  typedef struct packed {
    gain_t                             out_gain;
    gain_t [NR_OF_CHANNELS-1:0]        ch_gain;
    logic  [NR_OF_CHANNELS-1:0]        pan;
  } mix_cfg_t;  // 74 bits

  localparam logic [NR_OF_CHANNELS-1:0] PAN_RESET = 2'b10;  // ch0 left, ch1 right

  typedef struct packed {
    logic                      out_clip;  // either side saturated
    logic [NR_OF_CHANNELS-1:0] ch_clip;   // per channel gain stage
  } clip_t;  // 3 bits

endpackage

`default_nettype wire

// File: source/channel_mixer.sv
// two stage mixer, stage one applies channel gains, stage two pans, sums
// and applies the output gain; shifts round toward minus infinity
// clip is only meaningful with an accepted output frame

`timescale 1ns/100ps
`default_nettype none

module channel_mixer #(
  parameter int Q_BITS = audio_pkg::Q_BITS
) (
  input  wire                  clk,
  input  wire                  rst_n,
  input  wire audio_pkg::frame_t frm,
  input  wire                  frm_valid,
  output logic                 frm_ready,
  input  wire audio_pkg::mix_cfg_t cfg,
  output audio_pkg::frame_t    mix,
  output logic                 mix_valid,
  input  wire                  mix_ready,
  output audio_pkg::clip_t     clip
);

  import audio_pkg::*;

  // wide enough for (sum of two samples) * unsigned gain
  localparam int WIDE_W = AUDIO_WIDTH + GAIN_WIDTH + 3;

  sample_t                   in_ch [NR_OF_CHANNELS];
  sample_t                   sc_ch [NR_OF_CHANNELS];  // stage one comb result
  logic [NR_OF_CHANNELS-1:0] sc_clip;
  sample_t                   s1_ch [NR_OF_CHANNELS];
  logic [NR_OF_CHANNELS-1:0] s1_clip;
  logic                      s1_valid;
  logic signed [WIDE_W-1:0]  out_l_w;
  logic signed [WIDE_W-1:0]  out_r_w;
  logic                      stall;

  function automatic logic is_over(input logic signed [WIDE_W-1:0] v);
    return (v > SAMPLE_MAX) || (v < SAMPLE_MIN);
  endfunction

  function automatic sample_t saturate(input logic signed [WIDE_W-1:0] v);
    if (v > SAMPLE_MAX) begin
      return SAMPLE_MAX;
    end else if (v < SAMPLE_MIN) begin
      return SAMPLE_MIN;
    end
    return v[AUDIO_WIDTH-1:0];
  endfunction

  assign in_ch[0] = frm.left;   // channel 0
  assign in_ch[1] = frm.right;  // channel 1

  // whole pipe freezes on output back-pressure
  assign stall     = mix_valid && !mix_ready;
  assign frm_ready = !stall;

  // ---------------------------------------------------------------------
  // stage one, channel gain
  // ---------------------------------------------------------------------
  always_comb begin : gain_comb
    logic signed [WIDE_W-1:0] scaled;
    scaled = '0;
    for (int c = 0; c < NR_OF_CHANNELS; c++) begin
      scaled = ($signed(in_ch[c]) * $signed({1'b0, cfg.ch_gain[c]})) >>> Q_BITS;
      sc_ch[c]   = saturate(scaled);
      sc_clip[c] = is_over(scaled);
    end
  end

  // ---------------------------------------------------------------------
  // stage two, pan, sum and output gain
  // ---------------------------------------------------------------------
  always_comb begin : sum_comb
    logic signed [WIDE_W-1:0] sum_l;
    logic signed [WIDE_W-1:0] sum_r;
    sum_l = '0;
    sum_r = '0;
    for (int c = 0; c < NR_OF_CHANNELS; c++) begin
      if (cfg.pan[c]) begin
        sum_r = sum_r + $signed(s1_ch[c]);
      end else begin
        sum_l = sum_l + $signed(s1_ch[c]);
      end
    end
    out_l_w = (sum_l * $signed({1'b0, cfg.out_gain})) >>> Q_BITS;
    out_r_w = (sum_r * $signed({1'b0, cfg.out_gain})) >>> Q_BITS;
  end

  always_ff @(posedge clk or negedge rst_n) begin : valid_p
    if (!rst_n) begin
      s1_valid  <= 1'b0;
      mix_valid <= 1'b0;
    end else if (!stall) begin
      s1_valid  <= frm_valid;
      mix_valid <= s1_valid;
    end
  end

  always_ff @(posedge clk) begin : data_p
    if (!stall) begin
      s1_ch         <= sc_ch;
      s1_clip       <= sc_clip;
      mix.left      <= saturate(out_l_w);
      mix.right     <= saturate(out_r_w);
      clip.ch_clip  <= s1_clip;                              // carried along
      clip.out_clip <= is_over(out_l_w) || is_over(out_r_w);
    end
  end

endmodule

`default_nettype wire

// File: source/frame_assembler.sv
// pairs left/right samples into frames, adc_last marks the right sample
// a left sample without a following right one is overwritten by the next
// peaks follow every accepted sample, signed

`timescale 1ns/100ps
`default_nettype none

module frame_assembler (
  input  wire                  clk,
  input  wire                  rst_n,
  input  wire audio_pkg::sample_t adc_data,
  input  wire                  adc_last,
  input  wire                  adc_valid,
  output logic                 adc_ready,
  output audio_pkg::frame_t    frm,
  output logic                 frm_valid,
  input  wire                  frm_ready,
  input  wire                  peak_clear,
  output audio_pkg::sample_t   max_amp,
  output audio_pkg::sample_t   min_amp
);

  import audio_pkg::*;

  sample_t left_q;    // waiting for its right partner
  logic    adc_fire;

  // stall only while the held frame is not taken this cycle
  assign adc_ready = !frm_valid || frm_ready;
  assign adc_fire  = adc_valid && adc_ready;

  // ---------------------------------------------------------------------
  // pairing
  // ---------------------------------------------------------------------
  always_ff @(posedge clk) begin : pair_data_p
    if (adc_fire && !adc_last) begin
      left_q <= adc_data;
    end
    if (adc_fire && adc_last) begin
      frm.left  <= left_q;
      frm.right <= adc_data;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin : pair_valid_p
    if (!rst_n) begin
      frm_valid <= 1'b0;
    end else begin
      if (adc_fire && adc_last) begin
        frm_valid <= 1'b1;                 // next cycle after right sample
      end else if (frm_ready) begin
        frm_valid <= 1'b0;
      end
    end
  end

  // ---------------------------------------------------------------------
  // peak tracking
  // ---------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin : peak_p
    if (!rst_n) begin
      max_amp <= SAMPLE_MIN;   // anything beats it
      min_amp <= SAMPLE_MAX;
    end else if (peak_clear) begin
      max_amp <= SAMPLE_MIN;   // clear wins over a sample in the same cycle
      min_amp <= SAMPLE_MAX;
    end else if (adc_fire) begin
      if ($signed(adc_data) > $signed(max_amp)) begin
        max_amp <= adc_data;
      end
      if ($signed(adc_data) < $signed(min_amp)) begin
        min_amp <= adc_data;
      end
    end
  end

endmodule

`default_nettype wire

// File: source/frame_serializer.sv
// sends each mixed frame as left then right, dac_last on the right sample
// one frame at a time, mix_ready only while idle

`timescale 1ns/100ps
`default_nettype none

module frame_serializer (
  input  wire                  clk,
  input  wire                  rst_n,
  input  wire audio_pkg::frame_t mix,
  input  wire                  mix_valid,
  output logic                 mix_ready,
  output audio_pkg::sample_t   dac_data,
  output logic                 dac_last,
  output logic                 dac_valid,
  input  wire                  dac_ready
);

  import audio_pkg::*;

  typedef enum logic [1:0] {
    SER_IDLE,
    SER_SEND_LEFT,
    SER_SEND_RIGHT
  } ser_state_t;

  ser_state_t state;
  sample_t    right_q;  // parked while left is on the bus

  assign mix_ready = (state == SER_IDLE);

  always_ff @(posedge clk) begin : data_p
    if (state == SER_IDLE && mix_valid) begin
      right_q  <= mix.right;
      dac_data <= mix.left;
    end else if (state == SER_SEND_LEFT && dac_ready) begin
      dac_data <= right_q;
    end
  end

  // ---------------------------------------------------------------------
  // egress FSM
  // ---------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin : fsm_p
    if (!rst_n) begin
      state     <= SER_IDLE;
      dac_last  <= 1'b0;
      dac_valid <= 1'b0;
    end else begin
      case (state)
        SER_IDLE: begin
          if (mix_valid) begin
            state     <= SER_SEND_LEFT;
            dac_last  <= 1'b0;
            dac_valid <= 1'b1;      // cycle after the frame is taken
          end
        end
        SER_SEND_LEFT: begin
          if (dac_ready) begin
            state    <= SER_SEND_RIGHT;
            dac_last <= 1'b1;       // right sample closes the frame
          end
        end
        SER_SEND_RIGHT: begin
          if (dac_ready) begin
            state     <= SER_IDLE;
            dac_last  <= 1'b0;
            dac_valid <= 1'b0;
          end
        end
        default: begin
          state     <= SER_IDLE;
          dac_valid <= 1'b0;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: source/mixer_regs.sv
// four-phase register slave, one access per req/ack cycle
// writes to read-only addresses are dropped, unmapped reads give 0
// gain resets use the package Q_BITS

`timescale 1ns/100ps
`default_nettype none

module mixer_regs (
  input  wire                    clk,
  input  wire                    rst_n,
  input  wire regs_pkg::reg_req_t reg_req,
  input  wire                    reg_req_valid,
  output logic                   reg_ack,
  output regs_pkg::data_t        reg_rdata,
  output audio_pkg::mix_cfg_t    cfg,
  output logic                   peak_clear,
  input  wire audio_pkg::sample_t max_amp,
  input  wire audio_pkg::sample_t min_amp,
  input  wire audio_pkg::clip_t  clip,
  input  wire                    clip_valid
);

  import audio_pkg::*;
  import regs_pkg::*;

  clip_t clip_sticky;
  data_t rd_value;
  logic  access;   // first cycle of a request
  logic  wr_en;
  logic  clip_clear;

  assign access     = reg_req_valid && !reg_ack;
  assign wr_en      = access && reg_req.write;
  assign clip_clear = wr_en && (reg_req.addr == ADDR_CMD) && reg_req.data[CMD_CLIP_CLEAR];

  // ---------------------------------------------------------------------
  // read mux
  // ---------------------------------------------------------------------
  always_comb begin : read_mux
    rd_value = '0;
    case (reg_req.addr)
      ADDR_VERSION:  rd_value = HW_VERSION;
      ADDR_OUT_GAIN: rd_value = data_t'(cfg.out_gain);
      ADDR_CH0_GAIN: rd_value = data_t'(cfg.ch_gain[0]);
      ADDR_CH1_GAIN: rd_value = data_t'(cfg.ch_gain[1]);
      ADDR_PAN:      rd_value = data_t'(cfg.pan);
      ADDR_MAX_AMP:  rd_value = {{(32-AUDIO_WIDTH){max_amp[AUDIO_WIDTH-1]}}, max_amp};
      ADDR_MIN_AMP:  rd_value = {{(32-AUDIO_WIDTH){min_amp[AUDIO_WIDTH-1]}}, min_amp};
      ADDR_CLIP:     rd_value = data_t'(clip_sticky);
      default:       rd_value = '0;   // also the write-only ADDR_CMD
    endcase
  end

  // ---------------------------------------------------------------------
  // handshake and writes
  // ---------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin : regs_p
    if (!rst_n) begin
      reg_ack      <= 1'b0;
      reg_rdata    <= '0;
      cfg.out_gain <= UNITY_GAIN;
      for (int c = 0; c < NR_OF_CHANNELS; c++) begin
        cfg.ch_gain[c] <= UNITY_GAIN;
      end
      cfg.pan      <= PAN_RESET;
      peak_clear   <= 1'b0;
    end else begin
      peak_clear <= 1'b0;           // pulse
      if (access) begin
        reg_ack   <= 1'b1;          // one cycle after req seen high
        reg_rdata <= reg_req.write ? '0 : rd_value;
      end else if (!reg_req_valid && reg_ack) begin
        reg_ack <= 1'b0;            // one cycle after req seen low
      end
      if (wr_en) begin
        case (reg_req.addr)
          ADDR_OUT_GAIN: cfg.out_gain   <= reg_req.data[GAIN_WIDTH-1:0];
          ADDR_CH0_GAIN: cfg.ch_gain[0] <= reg_req.data[GAIN_WIDTH-1:0];
          ADDR_CH1_GAIN: cfg.ch_gain[1] <= reg_req.data[GAIN_WIDTH-1:0];
          ADDR_PAN:      cfg.pan        <= reg_req.data[NR_OF_CHANNELS-1:0];
          ADDR_CMD:      peak_clear     <= reg_req.data[CMD_PEAK_CLEAR];
          default: ;                // read-only or unmapped
        endcase
      end
    end
  end

  // sticky clip status
  always_ff @(posedge clk or negedge rst_n) begin : clip_p
    if (!rst_n) begin
      clip_sticky <= '0;
    end else if (clip_clear) begin
      clip_sticky <= '0;
    end else if (clip_valid) begin
      clip_sticky <= clip_sticky | clip;
    end
  end

endmodule

`default_nettype wire

// File: source/regs_pkg.sv
// register port types and register map of the mixer control block
// byte addresses, one 32 bit register per word, no byte strobes

`default_nettype none

package regs_pkg;

  typedef logic [6:0]  addr_t;
  typedef logic [31:0] data_t;

  typedef struct packed {
    logic  write;  // 1 write, 0 read
    addr_t addr;
    data_t data;
  } reg_req_t;  // 40 bits

  // ---------------------------------------------------------------------
  // register map
  // ---------------------------------------------------------------------
  localparam addr_t ADDR_VERSION  = 7'h00;  // ro
  localparam addr_t ADDR_OUT_GAIN = 7'h04;  // rw
  localparam addr_t ADDR_CH0_GAIN = 7'h08;  // rw
  localparam addr_t ADDR_CH1_GAIN = 7'h0C;  // rw
  localparam addr_t ADDR_PAN      = 7'h10;  // rw, bit per channel
  localparam addr_t ADDR_MAX_AMP  = 7'h14;  // ro, sign extended
  localparam addr_t ADDR_MIN_AMP  = 7'h18;  // ro, sign extended
  localparam addr_t ADDR_CLIP     = 7'h1C;  // ro, sticky
  localparam addr_t ADDR_CMD      = 7'h20;  // wo, self clearing

  // command bits in ADDR_CMD
  localparam int CMD_PEAK_CLEAR = 0;
  localparam int CMD_CLIP_CLEAR = 1;

  localparam data_t HW_VERSION = 32'd2058;

endpackage

`default_nettype wire
